/* all.f */
+incdir+logic
logic/lsu_pkg.sv
logic/load_unit.sv
logic/store_unit.sv
logic/wb_arbiter.sv
logic/mmio_timer.sv
logic/load_store_unit.sv
tests/lsu_chk.sv
tests/tb_load_store_unit.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f all.f \
    --top-module tb_load_store_unit \
    --Mdir obj_dir -o sim_lsu
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi

exit 0

/* tests/tb_load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module tb_load_store_unit;
    import lsu_pkg::*;

    localparam int TIMEOUT = 200;

    logic clk_i, rst_n_i, issue_valid_i, prv_level_i;
    lsu_op_t issue_op_i;
    addr_t issue_addr_i;
    word_t issue_data_i, commit_data_o, wb_adr_o, wb_dat_o, wb_dat_i;
    tag_t issue_tag_i, commit_tag_o;
    sel_t wb_sel_o;
    logic ldu_idle_o, stu_idle_o, commit_valid_o, commit_fault_o;
    logic wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i, timer_irq_o;

    logic [7:0]  mem [0:1023];
    logic [7:0]  ref_mem [0:1023];
    logic [31:0] rng;
    logic [1:0]  ack_wait;
    tag_t        next_tag;
    word_t       last_data;
    // Outstanding results, matched by tag
    tag_t        exp_tag [$];
    word_t       exp_data [$];
    logic        exp_fault [$];
    logic        exp_use_data [$];

    load_store_unit DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Initial memory contents, distinct for every byte address
    function automatic logic [7:0] fill_byte(input int a);
        return 8'((a * 37) ^ (a >> 8) ^ 8'h5A);
    endfunction

    // Expected result of a load, read from the modelled bytes
    function automatic word_t ref_load(input lsu_op_t op, input int a);
        logic [15:0] h;
        logic [7:0]  b;
        b = ref_mem[a];
        h = {ref_mem[(a + 1) % 1024], ref_mem[a]};
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            default: return {ref_mem[a + 3], ref_mem[a + 2], h};
        endcase
    endfunction

    task automatic ref_store(input lsu_op_t op, input int a, input word_t d);
        int n;
        n = (op == SB) ? 1 : (op == SH) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a + i] = d[8*i +: 8];
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%08h expected 0x%08h", name, got, exp);
            fail_now("Mismatch in a checked value");
        end
    endtask

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    // Waits for the target unit, drives one issue cycle and records the result
    task automatic issue(input lsu_op_t op, input addr_t a, input word_t d,
                         input logic prv, input word_t exp_d, input logic exp_f,
                         input logic use_d);
        int n;
        n = 0;
        while ((op inside {SB, SH, SW}) ? !stu_idle_o : !ldu_idle_o) begin
            tick();
            n++;
            if (n > TIMEOUT) fail_now("Timeout waiting for an idle unit");
        end
        exp_tag.push_back(next_tag);
        exp_data.push_back(exp_d);
        exp_fault.push_back(exp_f);
        exp_use_data.push_back(use_d);
        issue_valid_i = 1'b1;
        issue_op_i    = op;
        issue_addr_i  = a;
        issue_data_i  = d;
        issue_tag_i   = next_tag;
        prv_level_i   = prv;
        next_tag      = next_tag + 4'd1;
        tick();
        issue_valid_i = 1'b0;
    endtask

    // Waits until every expected result has committed
    task automatic drain(input logic cyc_low);
        int n;
        n = 0;
        while (exp_tag.size() != 0) begin
            if (cyc_low) check_value("wb_cyc_o", wb_cyc_o, 0);
            tick();
            n++;
            if (n > TIMEOUT) fail_now("Timeout waiting for a commit");
        end
    endtask

    task automatic mem_op(input logic store);
        lsu_op_t op;
        int      a;
        word_t   d;
        rng = xorshift(rng);
        op  = store ? lsu_op_t'(3'(5 + rng[3:0] % 3)) : lsu_op_t'(3'(rng[3:0] % 5));
        a   = int'(rng[13:8]) + 64;
        if (op inside {LH, LHU, SH}) a = a & ~1;
        if (op inside {LW, SW}) a = a & ~3;
        d = xorshift(rng);
        if (store) begin
            ref_store(op, a, d);
            issue(op, a, d, 1'b1, 32'h0, 1'b0, 1'b1);
        end else begin
            issue(op, a, 32'h0, 1'b1, ref_load(op, a), 1'b0, 1'b1);
        end
    endtask

    // ========================================================================
    // Wishbone memory model with a random ack delay
    // ========================================================================

    always @(posedge clk_i) begin
        wb_ack_i <= 1'b0;
        if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
            if (ack_wait == 2'd0) begin
                wb_ack_i <= 1'b1;
                for (int i = 0; i < 4; i++) begin
                    if (wb_we_o && wb_sel_o[i]) begin
                        mem[{wb_adr_o[9:2], 2'(i)}] = wb_dat_o[8*i +: 8];
                    end
                    wb_dat_i[8*i +: 8] <= mem[{wb_adr_o[9:2], 2'(i)}];
                end
                rng = xorshift(rng);
                ack_wait <= rng[1:0];
            end else begin
                ack_wait <= ack_wait - 2'd1;
            end
        end
    end

    // Compare process for the commit port
    always @(negedge clk_i) begin
        int idx;
        idx = -1;
        if (rst_n_i && commit_valid_o) begin
            for (int i = 0; i < exp_tag.size(); i++) begin
                if (exp_tag[i] == commit_tag_o) idx = i;
            end
            if (idx < 0) fail_now("A commit arrived with a tag that was never issued");
            check_value("commit_fault_o", commit_fault_o, exp_fault[idx]);
            if (exp_use_data[idx]) check_value("commit_data_o", commit_data_o, exp_data[idx]);
            last_data = commit_data_o;
            exp_tag.delete(idx);
            exp_data.delete(idx);
            exp_fault.delete(idx);
            exp_use_data.delete(idx);
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        word_t t0;
        int    n;
        tag_t  st_tag;
        tag_t  ld_tag;
        rng = 32'd90;
        ack_wait = 2'd0;
        next_tag = 4'd0;
        issue_valid_i = 1'b0;
        issue_op_i    = LW;
        issue_addr_i  = '0;
        issue_data_i  = '0;
        issue_tag_i   = '0;
        prv_level_i   = 1'b1;
        wb_dat_i      = '0;
        wb_ack_i      = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i]     = fill_byte(i);
            ref_mem[i] = fill_byte(i);
        end
        rst_n_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        tick();

        // Both units idle and nothing on the bus or the commit port
        check_value("commit_valid_o", commit_valid_o, 0);
        check_value("wb_cyc_o", wb_cyc_o, 0);
        check_value("wb_stb_o", wb_stb_o, 0);
        check_value("timer_irq_o", timer_irq_o, 0);
        check_value("ldu_idle_o", ldu_idle_o, 1);
        check_value("stu_idle_o", stu_idle_o, 1);

        // Random stores then random loads over a small window
        repeat (24) mem_op(1'b1);
        repeat (32) mem_op(1'b0);
        drain(1'b0);

        // Misaligned accesses never reach the bus
        issue(LH, 32'h101, 32'h0, 1'b1, 32'h0, 1'b1, 1'b1);
        drain(1'b1);
        issue(LW, 32'h102, 32'h0, 1'b1, 32'h0, 1'b1, 1'b1);
        drain(1'b1);
        issue(SH, 32'h103, 32'h1234, 1'b1, 32'h0, 1'b1, 1'b1);
        drain(1'b1);
        issue(SW, 32'h105, 32'h1234, 1'b1, 32'h0, 1'b1, 1'b1);
        drain(1'b1);

        // Load right behind a store to the same word
        ref_store(SW, 32'h200, 32'hCAFE_F00D);
        issue(SW, 32'h200, 32'hCAFE_F00D, 1'b1, 32'h0, 1'b0, 1'b1);
        issue(LW, 32'h200, 32'h0, 1'b1, ref_load(LW, 32'h200), 1'b0, 1'b1);
        ref_store(SB, 32'h203, 32'h0000_0080);
        issue(SB, 32'h203, 32'h0000_0080, 1'b1, 32'h0, 1'b0, 1'b1);
        issue(LB, 32'h203, 32'h0, 1'b1, ref_load(LB, 32'h203), 1'b0, 1'b1);
        drain(1'b0);

        // Store and load in flight together on different words
        for (int k = 0; k < 8; k++) begin
            ref_store(SW, 32'h300 + 8 * k, 32'h1111_0000 + k);
            issue(SW, 32'h300 + 8 * k, 32'h1111_0000 + k, 1'b1, 32'h0, 1'b0, 1'b1);
            issue(LW, 32'h304 + 8 * k, 32'h0, 1'b1, ref_load(LW, 32'h304 + 8 * k),
                  1'b0, 1'b1);
        end
        drain(1'b0);

        // A timer read issued in the store's ack cycle finishes together with
        // the store, so the load commits first and the store one cycle later
        st_tag = next_tag;
        ref_store(SW, 32'h340, 32'h2222_0001);
        issue(SW, 32'h340, 32'h2222_0001, 1'b1, 32'h0, 1'b0, 1'b1);
        n = 0;
        while (!wb_ack_i) begin
            tick();
            n++;
            if (n > TIMEOUT) fail_now("Timeout waiting for the store ack");
        end
        ld_tag = next_tag;
        // mtimecmp still holds its reset value of all ones
        issue(LW, `LSU_TIMER_BASE + `LSU_MTIMECMP_HI, 32'h0, 1'b1,
              32'hFFFF_FFFF, 1'b0, 1'b1);
        check_value("commit_valid_o", commit_valid_o, 1);
        check_value("commit_tag_o", commit_tag_o, ld_tag);
        tick();
        check_value("commit_valid_o", commit_valid_o, 1);
        check_value("commit_tag_o", commit_tag_o, st_tag);
        drain(1'b0);

        // Timer compare and interrupt
        issue(SW, `LSU_TIMER_BASE + `LSU_MTIMECMP_HI, 32'h0, 1'b1, 32'h0, 1'b0, 1'b1);
        issue(SW, `LSU_TIMER_BASE + `LSU_MTIMECMP_LO, 32'h40, 1'b1, 32'h0, 1'b0, 1'b1);
        drain(1'b0);
        n = 0;
        while (!timer_irq_o) begin
            tick();
            n++;
            if (n > TIMEOUT) fail_now("Timer interrupt did not rise");
        end
        issue(SW, `LSU_TIMER_BASE + `LSU_MTIMECMP_LO, '1, 1'b1, 32'h0, 1'b0, 1'b1);
        issue(SW, `LSU_TIMER_BASE + `LSU_MTIMECMP_HI, '1, 1'b1, 32'h0, 1'b0, 1'b1);
        drain(1'b0);
        n = 0;
        while (timer_irq_o) begin
            tick();
            n++;
            if (n > TIMEOUT) fail_now("Timer interrupt did not fall");
        end
        // Below machine level these writes fault and mtimecmp keeps all ones
        issue(SW, `LSU_TIMER_BASE + `LSU_MTIMECMP_HI, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1);
        issue(SW, `LSU_TIMER_BASE + `LSU_MTIMECMP_LO, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1);
        drain(1'b0);
        repeat (16) begin
            tick();
            check_value("timer_irq_o", timer_irq_o, 0);
        end

        // Two reads of mtime low must increase
        issue(LW, `LSU_TIMER_BASE + `LSU_MTIME_LO, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0);
        drain(1'b0);
        t0 = last_data;
        issue(LW, `LSU_TIMER_BASE + `LSU_MTIME_LO, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0);
        drain(1'b0);
        check_value("mtime_increase", last_data > t0, 1);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/lsu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_chk (
    input wire logic        clk_i,
    input wire logic        rst_n_i,
    input wire logic        wb_cyc_o,
    input wire logic        wb_stb_o,
    input wire logic        wb_we_o,
    input wire logic [31:0] wb_adr_o,
    input wire logic [3:0]  wb_sel_o,
    input wire logic [31:0] wb_dat_o,
    input wire logic        wb_ack_i,
    input wire logic        commit_valid_o
);

    // A strobe without an open cycle is not a legal Wishbone transfer
    a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_o |-> wb_cyc_o)
        else $error("stb high while cyc is low");

    // The master holds the request steady until the slave answers
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_cyc_o && !wb_ack_i) |=> (wb_cyc_o && $stable(wb_we_o) &&
        $stable(wb_adr_o) && $stable(wb_sel_o) && $stable(wb_dat_o)))
        else $error("Wishbone request changed before ack");

    a_commit_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(commit_valid_o))
        else $error("commit_valid_o is unknown");

endmodule

bind load_store_unit lsu_chk u_chk (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_we_o        (wb_we_o),
    .wb_adr_o       (wb_adr_o),
    .wb_sel_o       (wb_sel_o),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_i       (wb_ack_i),
    .commit_valid_o (commit_valid_o)
);

`default_nettype wire

/* logic/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module load_store_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,
    // Issue
    input  logic              issue_valid_i,
    input  lsu_pkg::lsu_op_t  issue_op_i,
    input  lsu_pkg::addr_t    issue_addr_i,
    input  lsu_pkg::word_t    issue_data_i,
    input  lsu_pkg::tag_t     issue_tag_i,
    input  logic              prv_level_i,
    output logic              ldu_idle_o,
    output logic              stu_idle_o,
    // Commit
    output logic              commit_valid_o,
    output lsu_pkg::tag_t     commit_tag_o,
    output lsu_pkg::word_t    commit_data_o,
    output logic              commit_fault_o,
    // Wishbone classic master
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output lsu_pkg::addr_t    wb_adr_o,
    output lsu_pkg::sel_t     wb_sel_o,
    output lsu_pkg::word_t    wb_dat_o,
    input  lsu_pkg::word_t    wb_dat_i,
    input  logic              wb_ack_i,
    // Machine timer interrupt
    output logic              timer_irq_o
);
    import lsu_pkg::*;

    localparam addr_t TIMER_BASE = `LSU_TIMER_BASE;

    logic  timer_hit, is_load, ld_valid, st_valid;
    word_t timer_rd_data;
    logic  timer_we;
    logic  ld_req, ld_ack, st_req, st_ack;
    addr_t ld_adr, st_adr;
    word_t ld_dat, st_dat;
    sel_t  st_sel;
    logic  st_busy;
    addr_t st_busy_addr;
    logic  ld_res_valid, ld_res_fault, st_res_valid, st_res_fault, st_accept;
    tag_t  ld_res_tag, st_res_tag;
    word_t ld_res_data;

    // ========================================================================
    // Issue decode
    // ========================================================================

    // The timer region is 16 bytes, so the low four bits are the offset
    assign timer_hit = (issue_addr_i[31:4] == TIMER_BASE[31:4]);
    assign is_load   = issue_op_i inside {LB, LH, LW, LBU, LHU};
    assign ld_valid  = issue_valid_i & is_load;
    assign st_valid  = issue_valid_i & ~is_load;

    load_unit u_ldu (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (ld_valid),
        .op_i           (issue_op_i),
        .addr_i         (issue_addr_i),
        .tag_i          (issue_tag_i),
        .timer_hit_i    (timer_hit),
        .timer_data_i   (timer_rd_data),
        .st_busy_i      (st_busy),
        .st_addr_i      (st_busy_addr),
        .bus_req_o      (ld_req),
        .bus_adr_o      (ld_adr),
        .bus_ack_i      (ld_ack),
        .bus_dat_i      (ld_dat),
        .idle_o         (ldu_idle_o),
        .result_valid_o (ld_res_valid),
        .result_tag_o   (ld_res_tag),
        .result_data_o  (ld_res_data),
        .result_fault_o (ld_res_fault)
    );

    store_unit u_stu (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (st_valid),
        .op_i           (issue_op_i),
        .addr_i         (issue_addr_i),
        .data_i         (issue_data_i),
        .tag_i          (issue_tag_i),
        .prv_level_i    (prv_level_i),
        .timer_hit_i    (timer_hit),
        .timer_we_o     (timer_we),
        .bus_req_o      (st_req),
        .bus_adr_o      (st_adr),
        .bus_sel_o      (st_sel),
        .bus_dat_o      (st_dat),
        .bus_ack_i      (st_ack),
        .busy_o         (st_busy),
        .busy_addr_o    (st_busy_addr),
        .accepted_i     (st_accept),
        .idle_o         (stu_idle_o),
        .result_valid_o (st_res_valid),
        .result_tag_o   (st_res_tag),
        .result_fault_o (st_res_fault)
    );

    // Every store unit transfer is a write
    wb_arbiter u_arb (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .ld_req_i (ld_req),
        .ld_adr_i (ld_adr),
        .ld_ack_o (ld_ack),
        .ld_dat_o (ld_dat),
        .st_req_i (st_req),
        .st_we_i  (1'b1),
        .st_adr_i (st_adr),
        .st_sel_i (st_sel),
        .st_dat_i (st_dat),
        .st_ack_o (st_ack),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    // Timer writes and reads both use the issue address directly
    mmio_timer u_timer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .we_i        (timer_we),
        .wr_off_i    (issue_addr_i[3:0]),
        .wr_data_i   (issue_data_i),
        .rd_off_i    (issue_addr_i[3:0]),
        .rd_data_o   (timer_rd_data),
        .timer_irq_o (timer_irq_o)
    );

    // ========================================================================
    // Commit arbiter
    // ========================================================================

    // A load result always goes out at once, a store result waits its turn
    assign commit_valid_o = ld_res_valid | st_res_valid;
    assign st_accept      = st_res_valid & ~ld_res_valid;
    assign commit_tag_o   = ld_res_valid ? ld_res_tag : st_res_tag;
    assign commit_data_o  = ld_res_valid ? ld_res_data : '0;
    assign commit_fault_o = ld_res_valid ? ld_res_fault : st_res_fault;

endmodule

`default_nettype wire

/* logic/mmio_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module mmio_timer (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            we_i,
    input  logic [3:0]      wr_off_i,
    input  lsu_pkg::word_t  wr_data_i,
    input  logic [3:0]      rd_off_i,
    output lsu_pkg::word_t  rd_data_o,
    output logic            timer_irq_o
);
    import lsu_pkg::*;

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        irq_q;

    // ========================================================================
    // Time, compare and interrupt
    // ========================================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_q      <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
            // The interrupt follows the comparison one cycle later
            irq_q   <= (mtime_q >= mtimecmp_q);
            // A write replaces one 32-bit half and wins over the increment
            if (we_i) begin
                case (wr_off_i)
                    `LSU_MTIME_LO:    mtime_q[31:0]     <= wr_data_i;
                    `LSU_MTIME_HI:    mtime_q[63:32]    <= wr_data_i;
                    `LSU_MTIMECMP_LO: mtimecmp_q[31:0]  <= wr_data_i;
                    `LSU_MTIMECMP_HI: mtimecmp_q[63:32] <= wr_data_i;
                    default:          ;
                endcase
            end
        end
    end

    // Reads are combinational so a timer load completes in one cycle
    always_comb begin
        case (rd_off_i)
            `LSU_MTIME_LO:    rd_data_o = mtime_q[31:0];
            `LSU_MTIME_HI:    rd_data_o = mtime_q[63:32];
            `LSU_MTIMECMP_LO: rd_data_o = mtimecmp_q[31:0];
            `LSU_MTIMECMP_HI: rd_data_o = mtimecmp_q[63:32];
            default:          rd_data_o = '0;
        endcase
    end

    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

/* logic/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Load unit side
    input  logic            ld_req_i,
    input  lsu_pkg::addr_t  ld_adr_i,
    output logic            ld_ack_o,
    output lsu_pkg::word_t  ld_dat_o,
    // Store unit side
    input  logic            st_req_i,
    input  logic            st_we_i,
    input  lsu_pkg::addr_t  st_adr_i,
    input  lsu_pkg::sel_t   st_sel_i,
    input  lsu_pkg::word_t  st_dat_i,
    output logic            st_ack_o,
    // Wishbone classic master
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output logic            wb_we_o,
    output lsu_pkg::addr_t  wb_adr_o,
    output lsu_pkg::sel_t   wb_sel_o,
    output lsu_pkg::word_t  wb_dat_o,
    input  lsu_pkg::word_t  wb_dat_i,
    input  logic            wb_ack_i
);
    import lsu_pkg::*;

    logic busy_q;
    logic gnt_ld_q;
    logic gnt_ld;

    // While no cycle is open the grant follows the requests with the load
    // first, and once a cycle is open the registered grant holds until ack
    assign gnt_ld = busy_q ? gnt_ld_q : ld_req_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            gnt_ld_q <= 1'b0;
        end else begin
            busy_q <= wb_cyc_o & ~wb_ack_i;
            if (!busy_q) begin
                gnt_ld_q <= gnt_ld;
            end
        end
    end

    // cyc and stb move together, one transfer at a time
    assign wb_cyc_o = gnt_ld ? ld_req_i : st_req_i;
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = ~gnt_ld & st_we_i;
    assign wb_adr_o = gnt_ld ? ld_adr_i : st_adr_i;
    // Loads always read the whole word
    assign wb_sel_o = gnt_ld ? '1 : st_sel_i;
    assign wb_dat_o = gnt_ld ? '0 : st_dat_i;

    // The ack goes back only to the unit holding the grant
    assign ld_ack_o = wb_ack_i & wb_cyc_o & gnt_ld;
    assign st_ack_o = wb_ack_i & wb_cyc_o & ~gnt_ld;
    assign ld_dat_o = wb_dat_i;

endmodule

`default_nettype wire

/* logic/store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module store_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  lsu_pkg::lsu_op_t  op_i,
    input  lsu_pkg::addr_t    addr_i,
    input  lsu_pkg::word_t    data_i,
    input  lsu_pkg::tag_t     tag_i,
    input  logic              prv_level_i,
    input  logic              timer_hit_i,
    output logic              timer_we_o,
    output logic              bus_req_o,
    output lsu_pkg::addr_t    bus_adr_o,
    output lsu_pkg::sel_t     bus_sel_o,
    output lsu_pkg::word_t    bus_dat_o,
    input  logic              bus_ack_i,
    output logic              busy_o,
    output lsu_pkg::addr_t    busy_addr_o,
    input  logic              accepted_i,
    output logic              idle_o,
    output logic              result_valid_o,
    output lsu_pkg::tag_t     result_tag_o,
    output logic              result_fault_o
);
    import lsu_pkg::*;

    stu_state_t state_q;
    addr_t      addr_q;
    sel_t       sel_q;
    word_t      dat_q;
    tag_t       tag_q;
    logic       fault_q;
    logic       start;
    logic       fault;
    sel_t       sel;
    word_t      lanes;

    assign start = valid_i & (state_q == STU_IDLE);

    // Misaligned stores fault, and only machine level may write the timer
    assign fault = lsu_misaligned(op_i, addr_i[1:0]) |
                   (timer_hit_i & (prv_level_i != `LSU_PRV_MACHINE));
    assign timer_we_o = start & timer_hit_i & ~fault;

    // Store data is copied to every lane, the byte select picks the live ones
    always_comb begin
        case (op_i)
            SB: begin
                lanes = {4{data_i[7:0]}};
                sel   = 4'b0001 << addr_i[1:0];
            end
            SH: begin
                lanes = {2{data_i[15:0]}};
                sel   = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lanes = data_i;
                sel   = 4'b1111;
            end
        endcase
    end

    // ========================================================================
    // FSM
    // ========================================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= STU_IDLE;
        end else begin
            case (state_q)
                STU_IDLE: begin
                    if (start) begin
                        state_q <= (fault || timer_hit_i) ? STU_DONE : STU_BUS;
                    end
                end
                STU_BUS: begin
                    if (bus_ack_i) begin
                        state_q <= STU_DONE;
                    end
                end
                // The result waits here while a load owns the commit port
                default: begin
                    if (accepted_i) begin
                        state_q <= STU_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q  <= {addr_i[31:2], 2'b00};
            sel_q   <= sel;
            dat_q   <= lanes;
            tag_q   <= tag_i;
            fault_q <= fault;
        end
    end

    assign bus_req_o      = (state_q == STU_BUS);
    assign bus_adr_o      = addr_q;
    assign bus_sel_o      = sel_q;
    assign bus_dat_o      = dat_q;
    assign busy_o         = (state_q == STU_BUS);
    assign busy_addr_o    = addr_q;
    assign idle_o         = (state_q == STU_IDLE);
    assign result_valid_o = (state_q == STU_DONE);
    assign result_tag_o   = tag_q;
    assign result_fault_o = fault_q;

endmodule

`default_nettype wire

/* logic/load_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  lsu_pkg::lsu_op_t  op_i,
    input  lsu_pkg::addr_t    addr_i,
    input  lsu_pkg::tag_t     tag_i,
    input  logic              timer_hit_i,
    input  lsu_pkg::word_t    timer_data_i,
    input  logic              st_busy_i,
    input  lsu_pkg::addr_t    st_addr_i,
    output logic              bus_req_o,
    output lsu_pkg::addr_t    bus_adr_o,
    input  logic              bus_ack_i,
    input  lsu_pkg::word_t    bus_dat_i,
    output logic              idle_o,
    output logic              result_valid_o,
    output lsu_pkg::tag_t     result_tag_o,
    output lsu_pkg::word_t    result_data_o,
    output logic              result_fault_o
);
    import lsu_pkg::*;

    ldu_state_t state_q;
    lsu_op_t    op_q;
    addr_t      addr_q;
    tag_t       tag_q;
    word_t      data_q;
    logic       fault_q;
    logic       start;
    logic       misaligned;
    logic       hazard_now;
    logic       hazard_q;

    // Moves the addressed bytes down to lane 0 and extends them to a word
    function automatic word_t extend(input lsu_op_t op, input logic [1:0] off,
                                     input word_t raw);
        word_t sh;
        sh = raw >> {off, 3'b000};
        case (op)
            LB:      extend = {{24{sh[7]}}, sh[7:0]};
            LBU:     extend = {24'h0, sh[7:0]};
            LH:      extend = {{16{sh[15]}}, sh[15:0]};
            LHU:     extend = {16'h0, sh[15:0]};
            default: extend = sh;
        endcase
    endfunction

    assign start      = valid_i & (state_q == LDU_IDLE);
    assign misaligned = lsu_misaligned(op_i, addr_i[1:0]);

    // A store still on the bus to the same word blocks the load.
    // The check is done on the word address only
    assign hazard_now = st_busy_i & (st_addr_i[31:2] == addr_i[31:2]);
    assign hazard_q   = st_busy_i & (st_addr_i[31:2] == addr_q[31:2]);

    // ========================================================================
    // FSM
    // ========================================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= LDU_IDLE;
        end else begin
            case (state_q)
                LDU_IDLE: begin
                    // Faults and timer reads finish in one cycle
                    if (start) begin
                        if (misaligned || timer_hit_i) begin
                            state_q <= LDU_DONE;
                        end else if (hazard_now) begin
                            state_q <= LDU_HAZARD;
                        end else begin
                            state_q <= LDU_BUS;
                        end
                    end
                end
                LDU_HAZARD: begin
                    if (!hazard_q) begin
                        state_q <= LDU_BUS;
                    end
                end
                LDU_BUS: begin
                    if (bus_ack_i) begin
                        state_q <= LDU_DONE;
                    end
                end
                // Commit never stalls a load, so DONE lasts one cycle
                default: state_q <= LDU_IDLE;
            endcase
        end
    end

    // Payload of the load in flight
    always_ff @(posedge clk_i) begin
        if (start) begin
            op_q    <= op_i;
            addr_q  <= addr_i;
            tag_q   <= tag_i;
            fault_q <= misaligned;
            // Timer data is taken as a whole word
            data_q  <= misaligned ? '0 : timer_data_i;
        end else if ((state_q == LDU_BUS) && bus_ack_i) begin
            data_q <= extend(op_q, addr_q[1:0], bus_dat_i);
        end
    end

    assign bus_req_o      = (state_q == LDU_BUS);
    assign bus_adr_o      = {addr_q[31:2], 2'b00};
    assign idle_o         = (state_q == LDU_IDLE);
    assign result_valid_o = (state_q == LDU_DONE);
    assign result_tag_o   = tag_q;
    assign result_data_o  = data_q;
    assign result_fault_o = fault_q;

endmodule

`default_nettype wire

/* logic/lsu_pkg.sv */
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

    // Widths that carry a meaning across the stage
    typedef logic [`LSU_WB_DAT_W-1:0] word_t;
    typedef logic [`LSU_WB_ADR_W-1:0] addr_t;
    typedef logic [3:0]               tag_t;
    typedef logic [`LSU_WB_SEL_W-1:0] sel_t;

    // Memory operations, loads first and stores last
    typedef enum logic [2:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } lsu_op_t;

    // Load unit FSM
    typedef enum logic [1:0] {
        LDU_IDLE, LDU_HAZARD, LDU_BUS, LDU_DONE
    } ldu_state_t;

    // Store unit FSM
    typedef enum logic [1:0] {
        STU_IDLE, STU_BUS, STU_DONE
    } stu_state_t;

    // True when the low address bits do not suit the access size.
    // Byte accesses are always aligned
    function automatic logic lsu_misaligned(input lsu_op_t op, input logic [1:0] off);
        case (op)
            LH, LHU, SH: lsu_misaligned = off[0];
            LW, SW:      lsu_misaligned = (off != 2'b00);
            default:     lsu_misaligned = 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ============================================================================
// Memory map of the machine timer
// ============================================================================

// The timer occupies a 16-byte region starting at this address
`define LSU_TIMER_BASE 32'hFFFF_0000

// Byte offsets of the 32-bit timer registers inside the region
`define LSU_MTIME_LO    4'h0
`define LSU_MTIME_HI    4'h4
`define LSU_MTIMECMP_LO 4'h8
`define LSU_MTIMECMP_HI 4'hC

// Privilege value that may write the timer
`define LSU_PRV_MACHINE 1'b1

// ============================================================================
// Wishbone port widths
// ============================================================================

`define LSU_WB_ADR_W 32
`define LSU_WB_DAT_W 32
`define LSU_WB_SEL_W 4

`endif
